// File: hdl/rv_core_pkg.sv
/*
 * Shared definitions for the rv_core RV32I core:
 * widths, start address, opcode/ALU/branch/stage enums
 * and the packed structs passed between the stages.
 */
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] PC_START = 32'h0000_0000;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // values follow funct3 of the branch encodings.
    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_NONE = 3'b010,
        BR_LT   = 3'b100,
        BR_GE   = 3'b101,
        BR_LTU  = 3'b110,
        BR_GEU  = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK
    } stage_e;

    // ========================================
    // stage payloads
    // ========================================
    typedef struct packed {
        opcode_e   opcode;
        alu_op_e   alu_op;
        branch_e   branch;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      valid;   // low for unknown opcodes.
    } decoded_t;

    typedef struct packed {
        word_t result;
        logic  taken;
    } exec_t;

    typedef struct packed {
        word_t adr;
        word_t dat;
        logic  we;
    } bus_req_t;

endpackage

`default_nettype wire

// File: hdl/rv_decoder.sv
/*
 * Decode stage: turns the fetched word into opcode, ALU
 * operation, branch condition, register indices and the
 * sign-extended immediate, registered on enable.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_en,
    input  wire word_t    i_instr,
    output decoded_t      o_dec
);

    decoded_t   dec_next;
    logic [2:0] funct3;
    logic       alt;

    assign funct3 = i_instr[14:12];
    assign alt    = i_instr[30];   // funct7 bit 5.

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic a, input logic r);
        case (f3)
            3'b000:  alu_sel = (a && r) ? ALU_SUB : ALU_ADD;   // no SUBI.
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = a ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_next.opcode = opcode_e'(i_instr[6:0]);
        dec_next.alu_op = ALU_ADD;
        dec_next.branch = BR_NONE;
        dec_next.rd     = i_instr[11:7];
        dec_next.rs1    = i_instr[19:15];
        dec_next.rs2    = i_instr[24:20];
        dec_next.imm    = {{20{i_instr[31]}}, i_instr[31:20]};   // I-type.
        dec_next.valid  = 1'b1;
        case (i_instr[6:0])
            OPC_LUI, OPC_AUIPC: dec_next.imm = {i_instr[31:12], 12'b0};
            OPC_JAL: dec_next.imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                     i_instr[30:21], 1'b0};
            OPC_JALR, OPC_LOAD: dec_next.alu_op = ALU_ADD;
            OPC_BRANCH: begin
                dec_next.imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                i_instr[11:8], 1'b0};
                // 010 and 011 are reserved and never taken.
                if (funct3[2:1] != 2'b01) begin
                    dec_next.branch = branch_e'(funct3);
                end
            end
            OPC_STORE: dec_next.imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            OPC_OP_IMM: dec_next.alu_op = alu_sel(funct3, alt, 1'b0);
            OPC_OP:     dec_next.alu_op = alu_sel(funct3, alt, 1'b1);
            default:    dec_next.valid  = 1'b0;   // runs as a no-op.
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_dec <= '0;
        end else if (i_en) begin
            o_dec <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
/*
 * General register file, x0..x31.
 * Two combinational read ports, one write port.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire reg_addr_t i_rs1_addr,
    input  wire reg_addr_t i_rs2_addr,
    input  wire logic      i_we,
    input  wire reg_addr_t i_rd_addr,
    input  wire word_t     i_rd_data,
    output word_t          o_rs1_data,
    output word_t          o_rs2_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];   // x0 hardwired.
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: hdl/rv_execute.sv
/*
 * Execute stage: operand selection, ALU and branch compare.
 * Result and branch decision are registered on enable.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_en,
    input  wire decoded_t i_dec,
    input  wire word_t    i_pc,
    input  wire word_t    i_rs1_data,
    input  wire word_t    i_rs2_data,
    output exec_t         o_exec
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    exec_t      exec_next;

    assign op_a  = (i_dec.opcode inside {OPC_AUIPC, OPC_JAL, OPC_BRANCH}) ? i_pc : i_rs1_data;
    assign op_b  = (i_dec.opcode == OPC_OP) ? i_rs2_data : i_dec.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_dec.alu_op)
            ALU_SUB:  exec_next.result = op_a - op_b;
            ALU_SLL:  exec_next.result = op_a << shamt;
            ALU_SLT:  exec_next.result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: exec_next.result = word_t'(op_a < op_b);
            ALU_XOR:  exec_next.result = op_a ^ op_b;
            ALU_SRL:  exec_next.result = op_a >> shamt;
            ALU_SRA:  exec_next.result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   exec_next.result = op_a | op_b;
            ALU_AND:  exec_next.result = op_a & op_b;
            default:  exec_next.result = op_a + op_b;
        endcase

        // branches always compare the two registers.
        case (i_dec.branch)
            BR_EQ:   exec_next.taken = (i_rs1_data == i_rs2_data);
            BR_NE:   exec_next.taken = (i_rs1_data != i_rs2_data);
            BR_LT:   exec_next.taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            BR_GE:   exec_next.taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            BR_LTU:  exec_next.taken = (i_rs1_data < i_rs2_data);
            BR_GEU:  exec_next.taken = (i_rs1_data >= i_rs2_data);
            default: exec_next.taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_exec <= '0;
        end else if (i_en) begin
            o_exec <= exec_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_bus_master.sv
/*
 * Wishbone classic master.
 * Latches one request on start, holds cyc/stb until ack,
 * then returns a one-cycle done pulse with the read word.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_master import rv_core_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_start,
    input  wire bus_req_t i_req,
    input  wire word_t    i_wb_dat,
    input  wire logic     i_wb_ack,
    output logic          o_done,
    output word_t         o_rdata,
    output logic          o_wb_cyc,
    output logic          o_wb_stb,
    output logic          o_wb_we,
    output logic [3:0]    o_wb_sel,
    output word_t         o_wb_adr,
    output word_t         o_wb_dat
);

    bus_req_t req_q;
    logic     cyc_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cyc_q  <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= cyc_q && i_wb_ack;   // pulse.
            if (cyc_q && i_wb_ack) begin
                cyc_q <= 1'b0;
            end else if (i_start) begin
                cyc_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !cyc_q) begin
            req_q <= i_req;
        end
        if (cyc_q && i_wb_ack) begin
            o_rdata <= i_wb_dat;
        end
    end

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = cyc_q;
    assign o_wb_we  = req_q.we;
    assign o_wb_sel = 4'b1111;   // word accesses only.
    assign o_wb_adr = req_q.adr;
    assign o_wb_dat = req_q.dat;

endmodule

`default_nettype wire

// File: hdl/rv_sequencer.sv
/*
 * Stage FSM: fetch, decode, execute, memory, writeback.
 * Holds pc, next_pc, the fetched instruction and the
 * load word; builds bus requests and the register write.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_sequencer import rv_core_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire logic     i_bus_done,
    input  wire word_t    i_bus_rdata,
    input  wire decoded_t i_dec,
    input  wire exec_t    i_exec,
    input  wire word_t    i_rs2_data,
    output logic          o_bus_start,
    output bus_req_t      o_bus_req,
    output word_t         o_instr,
    output logic          o_dec_en,
    output logic          o_exec_en,
    output word_t         o_pc,
    output logic          o_rd_we,
    output reg_addr_t     o_rd_addr,
    output word_t         o_rd_data
);

    stage_e stage;
    word_t  pc;
    word_t  next_pc;
    word_t  load_q;
    logic   bus_pending;
    logic   is_mem;
    logic   take_jump;
    word_t  aligned_res;

    assign is_mem      = i_dec.valid && (i_dec.opcode inside {OPC_LOAD, OPC_STORE});
    assign take_jump   = i_dec.valid && ((i_dec.opcode inside {OPC_JAL, OPC_JALR}) ||
                         (i_dec.opcode == OPC_BRANCH && i_exec.taken));
    assign aligned_res = {i_exec.result[XLEN-1:2], 2'b00};   // word aligned.

    // ========================================
    // bus requests
    // ========================================
    assign o_bus_start = (stage == ST_FETCH || stage == ST_MEMORY) && !bus_pending;

    always_comb begin
        if (stage == ST_MEMORY) begin
            o_bus_req.adr = aligned_res;
            o_bus_req.dat = i_rs2_data;
            o_bus_req.we  = (i_dec.opcode == OPC_STORE);
        end else begin
            o_bus_req.adr = pc;
            o_bus_req.dat = '0;
            o_bus_req.we  = 1'b0;
        end
    end

    // ========================================
    // stage sequence
    // ========================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage       <= ST_FETCH;
            pc          <= PC_START;
            next_pc     <= PC_START;
            bus_pending <= 1'b0;
        end else begin
            if (o_bus_start) begin
                bus_pending <= 1'b1;
            end else if (i_bus_done) begin
                bus_pending <= 1'b0;
            end
            case (stage)
                ST_FETCH: if (i_bus_done) begin
                    next_pc <= pc + 4;   // also the link value.
                    stage   <= ST_DECODE;
                end
                ST_DECODE:  stage <= ST_EXECUTE;
                ST_EXECUTE: stage <= is_mem ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY:  if (i_bus_done) stage <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    pc    <= take_jump ? aligned_res : next_pc;
                    stage <= ST_FETCH;
                end
                default: stage <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == ST_FETCH && i_bus_done) begin
            o_instr <= i_bus_rdata;
        end
        if (stage == ST_MEMORY && i_bus_done) begin
            load_q <= i_bus_rdata;
        end
    end

    assign o_dec_en  = (stage == ST_DECODE);
    assign o_exec_en = (stage == ST_EXECUTE);
    assign o_pc      = pc;

    // writeback.
    always_comb begin
        case (i_dec.opcode)
            OPC_LUI:           o_rd_data = i_dec.imm;
            OPC_JAL, OPC_JALR: o_rd_data = next_pc;
            OPC_LOAD:          o_rd_data = load_q;
            default:           o_rd_data = i_exec.result;
        endcase
    end

    assign o_rd_addr = i_dec.rd;
    assign o_rd_we   = (stage == ST_WRITEBACK) && i_dec.valid && (i_dec.rd != '0) &&
                       !(i_dec.opcode inside {OPC_BRANCH, OPC_STORE});

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
/*
 * rv_core top level: multi-cycle RV32I core with a
 * Wishbone classic master port. Stage instances only.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    output logic       o_wb_cyc,
    output logic       o_wb_stb,
    output logic       o_wb_we,
    output logic [3:0] o_wb_sel,
    output word_t      o_wb_adr,
    output word_t      o_wb_dat,
    input  wire word_t i_wb_dat,
    input  wire logic  i_wb_ack
);

    logic      bus_start;
    logic      bus_done;
    bus_req_t  bus_req;
    word_t     bus_rdata;
    word_t     instr;
    logic      dec_en;
    logic      exec_en;
    decoded_t  dec;
    exec_t     exec_res;
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;

    rv_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_bus_done  (bus_done),
        .i_bus_rdata (bus_rdata),
        .i_dec       (dec),
        .i_exec      (exec_res),
        .i_rs2_data  (rs2_data),
        .o_bus_start (bus_start),
        .o_bus_req   (bus_req),
        .o_instr     (instr),
        .o_dec_en    (dec_en),
        .o_exec_en   (exec_en),
        .o_pc        (pc),
        .o_rd_we     (rd_we),
        .o_rd_addr   (rd_addr),
        .o_rd_data   (rd_data)
    );

    rv_bus_master u_bus (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (bus_start),
        .i_req    (bus_req),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack),
        .o_done   (bus_done),
        .o_rdata  (bus_rdata),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_sel (o_wb_sel),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat)
    );

    rv_decoder u_dec (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (dec_en),
        .i_instr (instr),
        .o_dec   (dec)
    );

    rv_regfile u_rf (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (dec.rs1),
        .i_rs2_addr (dec.rs2),
        .i_we       (rd_we),
        .i_rd_addr  (rd_addr),
        .i_rd_data  (rd_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_execute u_exe (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_en       (exec_en),
        .i_dec      (dec),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_exec     (exec_res)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * 40 ns clock, synchronous reset held for 3 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/rv_core_checker.sv
/*
 * Instruction-level reference model of the core.
 * Follows every Wishbone transfer, predicts address,
 * we and write data, and checks the handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker import rv_core_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic       i_wb_cyc,
    input  wire logic       i_wb_stb,
    input  wire logic       i_wb_we,
    input  wire logic [3:0] i_wb_sel,
    input  wire word_t      i_wb_adr,
    input  wire word_t      i_wb_wdat,
    input  wire word_t      i_wb_rdat,
    input  wire logic       i_wb_ack,
    output logic            o_done,
    output int              o_fetches,
    output int              o_mismatches,
    output int              o_other_errors
);

    localparam int MAX_FETCHES = 3000;
    localparam int WAIT_LIMIT  = 64;

    word_t regs [NUM_REGS];
    word_t pc;
    logic  stopped;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            o_mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        o_other_errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic word_t alu_model(input logic [2:0] f3, input logic sub, input logic sra,
                                        input word_t x, input word_t y);
        case (f3)
            3'b000:  alu_model = sub ? x - y : x + y;
            3'b001:  alu_model = x << y[4:0];
            3'b010:  alu_model = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  alu_model = (x < y) ? 32'd1 : 32'd0;
            3'b100:  alu_model = x ^ y;
            3'b101:  alu_model = sra ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  alu_model = x | y;
            default: alu_model = x & y;
        endcase
    endfunction

    task automatic set_reg(input logic [4:0] rd, input word_t v);
        if (rd != 5'd0) begin
            regs[rd] = v;   // x0 stays zero.
        end
    endtask

    // one bus transfer, from cyc rising to cyc falling.
    task automatic run_transfer(input word_t adr, input logic we, input word_t dat,
                                output word_t rdata);
        int    cnt;
        word_t adr_q;
        word_t dat_q;
        logic  we_q;
        cnt = 0;
        do begin
            @(posedge i_clk);
            cnt++;
        end while (!i_wb_cyc && cnt < WAIT_LIMIT);
        if (!i_wb_cyc) begin
            report_error("no bus request started in time");
            stopped = 1'b1;
            return;
        end
        check_value("o_wb_stb", 32'(i_wb_stb), 32'd1);
        check_value("o_wb_adr", i_wb_adr, adr);
        check_value("o_wb_we", 32'(i_wb_we), 32'(we));
        check_value("o_wb_sel", 32'(i_wb_sel), 32'hf);
        if (we) begin
            check_value("o_wb_dat", i_wb_wdat, dat);
        end
        adr_q = i_wb_adr;
        dat_q = i_wb_wdat;
        we_q  = i_wb_we;
        cnt = 0;
        while (!i_wb_ack && cnt < WAIT_LIMIT) begin
            @(posedge i_clk);
            cnt++;
            if (!(i_wb_cyc && i_wb_stb)) begin
                report_error("cyc or stb dropped before ack");
            end
            check_value("o_wb_adr (held)", i_wb_adr, adr_q);
            check_value("o_wb_we (held)", 32'(i_wb_we), 32'(we_q));
            check_value("o_wb_dat (held)", i_wb_wdat, dat_q);
        end
        if (!i_wb_ack) begin
            report_error("no ack seen in time");
            stopped = 1'b1;
            return;
        end
        rdata = i_wb_rdat;
        @(posedge i_clk);
        if (i_wb_cyc || i_wb_stb) begin
            report_error("cyc or stb still high after ack");
        end
    endtask

    task automatic step(input word_t w);
        word_t a;
        word_t b;
        word_t next;
        word_t addr;
        word_t rdata;
        logic  taken;
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        next = pc + 32'd4;
        case (w[6:0])
            OPC_LUI:   set_reg(w[11:7], {w[31:12], 12'b0});
            OPC_AUIPC: set_reg(w[11:7], pc + {w[31:12], 12'b0});
            OPC_JAL: begin
                set_reg(w[11:7], pc + 32'd4);
                next = (pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}) & ~32'd3;
            end
            OPC_JALR: begin
                next = (a + {{20{w[31]}}, w[31:20]}) & ~32'd3;
                set_reg(w[11:7], pc + 32'd4);
            end
            OPC_BRANCH: begin
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;   // reserved.
                endcase
                if (taken) begin
                    next = (pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0})
                           & ~32'd3;
                end
            end
            OPC_OP_IMM: set_reg(w[11:7], alu_model(w[14:12], 1'b0, w[30], a,
                                                   {{20{w[31]}}, w[31:20]}));
            OPC_OP:     set_reg(w[11:7], alu_model(w[14:12], w[30], w[30], a, b));
            OPC_LOAD: begin
                addr = (a + {{20{w[31]}}, w[31:20]}) & ~32'd3;
                run_transfer(addr, 1'b0, '0, rdata);
                set_reg(w[11:7], rdata);
            end
            OPC_STORE: begin
                addr = (a + {{20{w[31]}}, w[31:25], w[11:7]}) & ~32'd3;
                run_transfer(addr, 1'b1, b, rdata);
            end
            default: ;   // unknown opcode, no-op.
        endcase
        pc = next;
    endtask

    initial begin
        int    cnt;
        word_t instr;
        o_done         = 1'b0;
        o_fetches      = 0;
        o_mismatches   = 0;
        o_other_errors = 0;
        stopped        = 1'b0;
        pc             = PC_START;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        cnt = 0;
        do begin
            @(posedge i_clk);
            cnt++;
        end while (i_rst !== 1'b0 && cnt < WAIT_LIMIT);
        if (i_rst !== 1'b0) begin
            report_error("reset was never released");
            stopped = 1'b1;
        end else begin
            check_value("o_wb_cyc after reset", 32'(i_wb_cyc), 32'd0);
            check_value("o_wb_stb after reset", 32'(i_wb_stb), 32'd0);
        end
        while (!stopped && o_fetches < MAX_FETCHES) begin
            run_transfer(pc, 1'b0, '0, instr);
            if (!stopped) begin
                o_fetches++;
                step(instr);
            end
        end
        o_done = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/rv_core_tb.sv
/*
 * Testbench top for rv_core: random program memory,
 * Wishbone slave with random ack delay, the DUT and
 * the checker. Prints the closing summary.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ;

    localparam int MEM_WORDS = 1024;
    localparam int RUN_LIMIT = 200000;   // cycles.

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [3:0] wb_sel;
    word_t      wb_adr;
    word_t      wb_wdat;
    word_t      wb_rdat;
    logic       wb_ack;
    word_t      mem [MEM_WORDS];
    integer     seed;
    int         delay_left;
    logic       chk_done;
    int         mismatches;
    int         other_errors;
    int         fetches;
    int         cycles;

    tb_clock_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv_core u_rv_core (
        .i_clk    (clk),
        .i_rst    (rst),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_we  (wb_we),
        .o_wb_sel (wb_sel),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_wdat),
        .i_wb_dat (wb_rdat),
        .i_wb_ack (wb_ack)
    );

    rv_core_checker u_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_wb_cyc       (wb_cyc),
        .i_wb_stb       (wb_stb),
        .i_wb_we        (wb_we),
        .i_wb_sel       (wb_sel),
        .i_wb_adr       (wb_adr),
        .i_wb_wdat      (wb_wdat),
        .i_wb_rdat      (wb_rdat),
        .i_wb_ack       (wb_ack),
        .o_done         (chk_done),
        .o_fetches      (fetches),
        .o_mismatches   (mismatches),
        .o_other_errors (other_errors)
    );

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    // small word offset, mostly forward.
    function automatic logic [31:0] small_offset();
        logic [31:0] off;
        off = 32'((rand_below(8) + 1) * 4);
        if (rand_below(4) == 0) begin
            off = -off;
        end
        small_offset = off;
    endfunction

    function automatic word_t random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] off;
        logic [11:0] imm;
        word_t       w;
        rd  = 5'(rand_below(32));
        rs1 = 5'(rand_below(32));
        rs2 = 5'(rand_below(32));
        f3  = 3'(rand_below(8));
        imm = 12'(rand_below(4096));
        case (rand_below(12))
            0: w = {20'(rand_below(1 << 20)), rd, 7'b0110111};   // LUI.
            1: w = {20'(rand_below(1 << 20)), rd, 7'b0010111};   // AUIPC.
            2, 3: begin
                if (f3 == 3'b001) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                end
                w = {imm, rs1, f3, rd, 7'b0010011};
            end
            4, 5: begin
                imm[11:5] = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, imm[10], 5'b0} : 7'b0;
                w = {imm[11:5], rs2, rs1, f3, rd, 7'b0110011};
            end
            6, 7: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = 3'b000;
                end
                off = small_offset();
                w = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            8: begin
                off = small_offset();
                w = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end
            9: w = {12'(rand_below(512) * 4), 5'd0, 3'b000, rd, 7'b1100111};   // x0 base.
            10: w = {imm[11:2], 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
            default: w = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:2], 2'b00, 7'b0100011};
        endcase
        random_instr = w;
    endfunction

    initial begin
        seed   = 32'h60b5_f59e;
        wb_ack = 1'b0;
        wb_rdat = '0;
        delay_left = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = random_instr();
        end
    end

    // ========================================
    // memory slave
    // ========================================
    always @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            delay_left <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;   // one ack per transfer.
        end else if (wb_cyc && wb_stb) begin
            if (delay_left == 0) begin
                wb_ack  <= 1'b1;
                wb_rdat <= mem[wb_adr[11:2]];
                if (wb_we) begin
                    mem[wb_adr[11:2]] <= wb_wdat;
                end
                delay_left <= rand_below(4);
            end else begin
                delay_left <= delay_left - 1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (chk_done !== 1'b1 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (chk_done !== 1'b1) begin
            $display("Error: checker did not finish within %0d cycles", RUN_LIMIT);
        end
        $display("fetches=%0d mismatches=%0d other_errors=%0d",
                 fetches, mismatches, other_errors);
        if (chk_done === 1'b1 && mismatches == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_bus_master.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
verif/tb_clock_gen.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := rv_core_tb
RTL_TOP   := rv_core
FILELIST  := src.f
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Finished with errors" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -qx "Finished with no errors" $(LOG); then echo "simulation FAILED"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		hdl/rv_core_pkg.sv hdl/rv_decoder.sv hdl/rv_regfile.sv hdl/rv_execute.sv \
		hdl/rv_bus_master.sv hdl/rv_sequencer.sv hdl/rv_core.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
